// File: filelist.f
+incdir+hdl
hdl/AhbPkg.sv
hdl/DesPkg.sv
hdl/DesInterfaces.sv
hdl/AhbSlaveController.sv
hdl/TripleDesSequencer.sv
hdl/DesEngine.sv
hdl/TripleDesTop.sv
verification/TripleDes_properties.sv
verification/TripleDesChecker.sv
verification/TripleDesTb.sv

// File: Bender.yml
package:
  name: triple_des_ahb

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/AhbPkg.sv
      - hdl/DesPkg.sv
      - hdl/DesInterfaces.sv
      - hdl/AhbSlaveController.sv
      - hdl/TripleDesSequencer.sv
      - hdl/DesEngine.sv
      - hdl/TripleDesTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/TripleDes_properties.sv
      - verification/TripleDesChecker.sv
      - verification/TripleDesTb.sv

// File: verification/TripleDesTb.sv
`timescale 1ns/1ps
`include "TripleDes_defs.svh"

module TripleDesTb;

  typedef enum {EntryWrite, EntryRead, EntryError} EntryKind;

  typedef struct
  {
    EntryKind kind;
    logic write;
    logic [31:0] addr;
    logic [2:0] size;
    logic [2:0] burst;
    logic lock;
    logic [63:0] wdata;
    logic [63:0] expData;
  } Entry;

  localparam int DriveDelay = 1;
  localparam int CyclesPerEntry = 70;
  localparam logic [2:0] Size32 = 3'b010;
  localparam logic [2:0] Size64 = 3'b011;
  localparam logic [2:0] BurstSingle = 3'b000;
  localparam logic [2:0] BurstIncr = 3'b001;

  logic HCLK;
  logic HRESET;
  logic HSEL;
  logic [31:0] HADDR;
  AhbPkg::HtransType HTRANS;
  logic HWRITE;
  logic [2:0] HSIZE;
  logic [2:0] HBURST;
  logic HMASTLOCK;
  logic HREADY;
  logic [63:0] HWDATA;
  logic [63:0] HRDATA;
  logic HREADYOUT;
  logic HRESP;

  logic checkEn;
  logic expError;
  logic checkData;
  logic [63:0] expData;
  int entryIdx;
  int checkCount;
  int errorCount;
  int cycleCount = 0;
  int timeoutLimit = 0;
  logic [15:0] lfsr;
  Entry stimTable[$];

  // Single slave, so the bus HREADY is its own HREADYOUT
  assign HREADY = HREADYOUT;

  TripleDesTop uut
  (
    .HCLK(HCLK),
    .HRESET(HRESET),
    .HSEL(HSEL),
    .HADDR(HADDR),
    .HTRANS(HTRANS),
    .HWRITE(HWRITE),
    .HSIZE(HSIZE),
    .HBURST(HBURST),
    .HMASTLOCK(HMASTLOCK),
    .HREADY(HREADY),
    .HWDATA(HWDATA),
    .HRDATA(HRDATA),
    .HREADYOUT(HREADYOUT),
    .HRESP(HRESP)
  );

  TripleDesChecker respChecker
  (
    .HCLK(HCLK),
    .HRESET(HRESET),
    .HREADYOUT(HREADYOUT),
    .HRESP(HRESP),
    .HRDATA(HRDATA),
    .checkEn(checkEn),
    .expError(expError),
    .checkData(checkData),
    .expData(expData),
    .entryIdx(entryIdx),
    .checkCount(checkCount),
    .errorCount(errorCount)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  always @(posedge HCLK)
    cycleCount <= cycleCount + 1;

  initial
  begin
    wait (timeoutLimit > 0);
    wait (cycleCount >= timeoutLimit);
    $display("Timeout after %0d cycles, the bus hung waiting for HREADYOUT", cycleCount);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    if (state[0])
      return (state >> 1) ^ 16'hB400;
    return state >> 1;
  endfunction

  task automatic takeRandomBit(output logic b);
    b = lfsr[0];
    lfsr = lfsrNext(lfsr);
  endtask

  task automatic addEntry(input EntryKind kind, input logic write, input logic [31:0] addr,
                          input logic [2:0] size, input logic [2:0] burst, input logic lock,
                          input logic [63:0] wdata, input logic [63:0] expected);
    Entry e;
    e = '{kind, write, addr, size, burst, lock, wdata, expected};
    stimTable.push_back(e);
  endtask

  task automatic addWrite(input logic [31:0] ofs, input logic [63:0] data);
    addEntry(EntryWrite, 1'b1, `TDES_BASE + ofs, Size64, BurstSingle, 1'b0, data, '0);
  endtask

  task automatic addRead(input logic [31:0] ofs, input logic [63:0] expected);
    addEntry(EntryRead, 1'b0, `TDES_BASE + ofs, Size64, BurstSingle, 1'b0, '0, expected);
  endtask

  task automatic buildTable();
    // Register readback and single DES equivalence
    addWrite(`TDES_MODE_OFS, 64'hA5A5_0000_0000_0000);
    addRead(`TDES_MODE_OFS, 64'hA5A5_0000_0000_0000);
    addWrite(`TDES_KEY1_OFS, 64'h1334_5779_9BBC_DFF1);
    addWrite(`TDES_KEY2_OFS, 64'h1334_5779_9BBC_DFF1);
    addWrite(`TDES_KEY3_OFS, 64'h1334_5779_9BBC_DFF1);
    addRead(`TDES_KEY1_OFS, 64'h1334_5779_9BBC_DFF1);
    addWrite(`TDES_DATA_OFS, 64'h0123_4567_89AB_CDEF);
    addRead(`TDES_RESULT_OFS, 64'h85E8_1354_0F0A_B405);
    addWrite(`TDES_MODE_OFS, 64'h1);
    addWrite(`TDES_DATA_OFS, 64'h85E8_1354_0F0A_B405);
    addRead(`TDES_RESULT_OFS, 64'h0123_4567_89AB_CDEF);
    // SP 800-67 example with three keys
    addWrite(`TDES_KEY1_OFS, 64'h0123_4567_89AB_CDEF);
    addWrite(`TDES_KEY2_OFS, 64'h2345_6789_ABCD_EF01);
    addWrite(`TDES_KEY3_OFS, 64'h4567_89AB_CDEF_0123);
    addRead(`TDES_KEY2_OFS, 64'h2345_6789_ABCD_EF01);
    addRead(`TDES_KEY3_OFS, 64'h4567_89AB_CDEF_0123);
    addWrite(`TDES_MODE_OFS, 64'h0);
    addWrite(`TDES_DATA_OFS, 64'h5468_6520_7175_6663);
    // Second block is held while the first is busy
    addWrite(`TDES_DATA_OFS, 64'h6B20_6272_6F77_6E20);
    addRead(`TDES_RESULT_OFS, 64'hA826_FD8C_E53B_855F);
    addRead(`TDES_RESULT_OFS, 64'hCCE2_1C81_1225_6FE6);
    addWrite(`TDES_MODE_OFS, 64'h1);
    addWrite(`TDES_DATA_OFS, 64'hA826_FD8C_E53B_855F);
    addRead(`TDES_RESULT_OFS, 64'h5468_6520_7175_6663);
    addWrite(`TDES_DATA_OFS, 64'h68D5_C05D_D9B6_B900);
    addRead(`TDES_RESULT_OFS, 64'h666F_7820_6A75_6D70);
    // Illegal transfers, then the registers must be untouched
    addEntry(EntryError, 1'b1, `TDES_BASE + `TDES_KEY1_OFS, Size32, BurstSingle, 1'b0,
             64'hFFFF_FFFF_FFFF_FFFF, '0);
    addEntry(EntryError, 1'b1, `TDES_BASE + `TDES_KEY2_OFS, Size64, BurstIncr, 1'b0,
             64'hFFFF_FFFF_FFFF_FFFF, '0);
    addEntry(EntryError, 1'b1, `TDES_BASE + `TDES_KEY3_OFS, Size64, BurstSingle, 1'b1,
             64'hFFFF_FFFF_FFFF_FFFF, '0);
    addEntry(EntryError, 1'b0, `TDES_BASE + 32'h30, Size64, BurstSingle, 1'b0, '0, '0);
    addEntry(EntryError, 1'b1, `TDES_BASE + 32'h04, Size64, BurstSingle, 1'b0,
             64'hFFFF_FFFF_FFFF_FFFF, '0);
    addEntry(EntryError, 1'b1, `TDES_BASE + `TDES_RESULT_OFS, Size64, BurstSingle, 1'b0,
             64'hFFFF_FFFF_FFFF_FFFF, '0);
    addRead(`TDES_KEY1_OFS, 64'h0123_4567_89AB_CDEF);
    addRead(`TDES_KEY2_OFS, 64'h2345_6789_ABCD_EF01);
    addRead(`TDES_KEY3_OFS, 64'h4567_89AB_CDEF_0123);
    addRead(`TDES_MODE_OFS, 64'h1);
  endtask

  // One unpipelined transfer: random idle gap, address phase, data phase
  task automatic runEntry(input int idx);
    Entry e;
    logic b0;
    logic b1;
    e = stimTable[idx];
    takeRandomBit(b0);
    takeRandomBit(b1);
    repeat ({b1, b0})
    begin
      @(posedge HCLK);
      #(DriveDelay);
    end
    HADDR = e.addr;
    HTRANS = AhbPkg::TransNonSeq;
    HWRITE = e.write;
    HSIZE = e.size;
    HBURST = e.burst;
    HMASTLOCK = e.lock;
    @(posedge HCLK);
    #(DriveDelay);
    HTRANS = AhbPkg::TransIdle;
    HMASTLOCK = 1'b0;
    HWDATA = e.write ? e.wdata : '0;
    entryIdx = idx;
    expError = (e.kind == EntryError);
    checkData = (e.kind == EntryRead);
    expData = e.expData;
    checkEn = 1'b1;
    do
      @(negedge HCLK);
    while (!HREADYOUT);
    @(posedge HCLK);
    #(DriveDelay);
    checkEn = 1'b0;
  endtask

  initial
  begin
    int otherErrors;
    int assertFails;
    otherErrors = 0;
    HRESET = 1'b0;
    HSEL = 1'b0;
    HADDR = '0;
    HTRANS = AhbPkg::TransIdle;
    HWRITE = 1'b0;
    HSIZE = Size64;
    HBURST = BurstSingle;
    HMASTLOCK = 1'b0;
    HWDATA = '0;
    checkEn = 1'b0;
    expError = 1'b0;
    checkData = 1'b0;
    expData = '0;
    entryIdx = 0;
    lfsr = 16'd16;
    buildTable();
    timeoutLimit = stimTable.size() * CyclesPerEntry;
    repeat (3) @(posedge HCLK);
    #(DriveDelay);
    HRESET = 1'b1;
    HSEL = 1'b1;
    for (int i = 0; i < stimTable.size(); i++)
      runEntry(i);
    repeat (2) @(posedge HCLK);
    // Every entry ends in exactly one compared response
    if (checkCount != stimTable.size())
    begin
      $display("Only %0d of %0d bus responses were checked", checkCount, stimTable.size());
      otherErrors++;
    end
    assertFails = uut.props.failCount;
    $display("Checks %0d, compare errors %0d, assertion failures %0d, other errors %0d",
             checkCount, errorCount, assertFails, otherErrors);
    if (errorCount == 0 && assertFails == 0 && otherErrors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verification/TripleDesChecker.sv
`timescale 1ns/1ps

module TripleDesChecker
(
  input logic HCLK,
  input logic HRESET,
  input logic HREADYOUT,
  input logic HRESP,
  input logic [63:0] HRDATA,
  input logic checkEn,
  input logic expError,
  input logic checkData,
  input logic [63:0] expData,
  input int entryIdx,
  output int checkCount,
  output int errorCount
);

  // Outputs are settled mid-cycle, so compare on the falling edge
  always @(negedge HCLK)
  begin
    if (!HRESET)
    begin
      checkCount <= 0;
      errorCount <= 0;
    end
    else if (checkEn && HREADYOUT)
    begin
      checkCount <= checkCount + 1;
      if (HRESP !== expError)
      begin
        $display("FAIL HRESP entry %0d: got %h, expected %h", entryIdx, HRESP, expError);
        errorCount <= errorCount + 1;
      end
      else if (checkData && HRDATA !== expData)
      begin
        $display("FAIL HRDATA entry %0d: got %h, expected %h", entryIdx, HRDATA, expData);
        errorCount <= errorCount + 1;
      end
    end
  end

endmodule

// File: verification/TripleDes_properties.sv
`timescale 1ns/1ps

module TripleDesProperties
(
  input logic HCLK,
  input logic HRESET,
  input logic HREADYOUT,
  input logic HRESP
);

  int failCount = 0;

  // Bus response must be idle OKAY right after reset release
  resetIdle: assert property (@(posedge HCLK) $rose(HRESET) |-> HREADYOUT && !HRESP)
    else
    begin
      $error("HREADYOUT or HRESP not idle after reset");
      failCount++;
    end

  // First ERROR cycle is always followed by the second one
  errorTwoCycle: assert property (@(posedge HCLK) disable iff (!HRESET)
    (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT))
    else
    begin
      $error("ERROR response did not complete in two cycles");
      failCount++;
    end

  errorOnlyInSequence: assert property (@(posedge HCLK) disable iff (!HRESET)
    HRESP |-> !HREADYOUT || $past(HRESP && !HREADYOUT))
    else
    begin
      $error("HRESP high outside a two-cycle ERROR response");
      failCount++;
    end

endmodule

bind TripleDesTop TripleDesProperties props
(
  .HCLK(HCLK),
  .HRESET(HRESET),
  .HREADYOUT(HREADYOUT),
  .HRESP(HRESP)
);

// File: hdl/TripleDesTop.sv
`timescale 1ns/1ps

module TripleDesTop
(
  input logic HCLK,
  input logic HRESET,
  input logic HSEL,
  input logic [31:0] HADDR,
  input AhbPkg::HtransType HTRANS,
  input logic HWRITE,
  input logic [2:0] HSIZE,
  input logic [2:0] HBURST,
  input logic HMASTLOCK,
  input logic HREADY,
  input logic [63:0] HWDATA,
  output logic [63:0] HRDATA,
  output logic HREADYOUT,
  output logic HRESP
);

  TdesReqIf reqIf ();
  DesPassIf passIf ();

  AhbSlaveController controller
  (
    .HCLK(HCLK),
    .HRESET(HRESET),
    .HSEL(HSEL),
    .HADDR(HADDR),
    .HTRANS(HTRANS),
    .HWRITE(HWRITE),
    .HSIZE(HSIZE),
    .HBURST(HBURST),
    .HMASTLOCK(HMASTLOCK),
    .HREADY(HREADY),
    .HWDATA(HWDATA),
    .HRDATA(HRDATA),
    .HREADYOUT(HREADYOUT),
    .HRESP(HRESP),
    .req(reqIf.controller)
  );

  TripleDesSequencer sequencer
  (
    .HCLK(HCLK),
    .HRESET(HRESET),
    .req(reqIf.sequencer),
    .pass(passIf.requester)
  );

  DesEngine engine
  (
    .HCLK(HCLK),
    .HRESET(HRESET),
    .pass(passIf.engine)
  );

endmodule

// File: hdl/DesEngine.sv
`timescale 1ns/1ps
`include "TripleDes_defs.svh"

module DesEngine
(
  input logic HCLK,
  input logic HRESET,
  DesPassIf.engine pass
);

  typedef enum logic [1:0] {EngIdle, EngRound, EngFinal, EngDone} EngState;

  // Standard tables, entries count bits from 1 at the MSB
  localparam int IpTable [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7};
  localparam int ExpTable [48] = '{
    32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9, 8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29,
    30, 31, 32, 1};
  localparam int PTable [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25};
  localparam int Pc1Table [56] = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18, 10, 2, 59, 51, 43, 35, 27,
    19, 11, 3, 60, 52, 44, 36, 63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
    14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4};
  localparam int Pc2Table [48] = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4, 26, 8, 16, 7, 27, 20,
    13, 2, 41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48, 44, 49, 39, 56, 34, 53,
    46, 42, 50, 36, 29, 32};
  // Row-major S-boxes, first entry in the top nibble
  localparam logic [255:0] SBoxes [8] = '{
    256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
    256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
    256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
    256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
    256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
    256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
    256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
    256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B};

  EngState state;
  logic [3:0] roundCnt;
  DesPkg::CipherDir dir;
  DesPkg::DesBlock data;
  DesPkg::DesBlock nextData;
  logic [55:0] cd;
  logic [55:0] nextCd;

  function automatic logic [63:0] initialPerm(input logic [63:0] x);
    logic [63:0] y;
    for (int i = 0; i < 64; i++)
      y[63 - i] = x[64 - IpTable[i]];
    return y;
  endfunction

  // Inverse of the initial permutation
  function automatic logic [63:0] finalPerm(input logic [63:0] x);
    logic [63:0] y;
    for (int i = 0; i < 64; i++)
      y[64 - IpTable[i]] = x[63 - i];
    return y;
  endfunction

  function automatic logic [55:0] pc1(input logic [63:0] key);
    logic [55:0] y;
    for (int i = 0; i < 56; i++)
      y[55 - i] = key[64 - Pc1Table[i]];
    return y;
  endfunction

  function automatic logic [47:0] pc2(input logic [55:0] k);
    logic [47:0] y;
    for (int i = 0; i < 48; i++)
      y[47 - i] = k[56 - Pc2Table[i]];
    return y;
  endfunction

  // Decryption walks the schedule backwards, starting from C0D0 unrotated
  function automatic logic [55:0] rotateKey(input logic [55:0] k, input DesPkg::CipherDir d,
                                            input logic [3:0] round);
    logic [27:0] c;
    logic [27:0] e;
    int amount;
    c = k[55:28];
    e = k[27:0];
    if (round == 4'd0 || round == 4'd1 || round == 4'd8 || round == 4'd15)
      amount = 1;
    else
      amount = 2;
    if (d == DesPkg::Decrypt && round == 4'd0)
      amount = 0;
    for (int s = 0; s < 2; s++)
    begin
      if (s < amount && d == DesPkg::Encrypt)
      begin
        c = {c[26:0], c[27]};
        e = {e[26:0], e[27]};
      end
      else if (s < amount)
      begin
        c = {c[0], c[27:1]};
        e = {e[0], e[27:1]};
      end
    end
    return {c, e};
  endfunction

  function automatic logic [31:0] feistel(input logic [31:0] r, input logic [47:0] subKey);
    logic [47:0] x;
    logic [31:0] s;
    logic [31:0] y;
    logic [5:0] chunk;
    int idx;
    for (int i = 0; i < 48; i++)
      x[47 - i] = r[32 - ExpTable[i]];
    x = x ^ subKey;
    for (int n = 0; n < 8; n++)
    begin
      chunk = x[47 - 6 * n -: 6];
      idx = 16 * {chunk[5], chunk[0]} + chunk[4:1];
      s[31 - 4 * n -: 4] = SBoxes[n][255 - 4 * idx -: 4];
    end
    for (int i = 0; i < 32; i++)
      y[31 - i] = s[32 - PTable[i]];
    return y;
  endfunction

  always_comb
  begin
    nextCd = rotateKey(cd, dir, roundCnt);
    nextData.halves.left = data.halves.right;
    nextData.halves.right = data.halves.left ^ feistel(data.halves.right, pc2(nextCd));
  end

  always_ff @(posedge HCLK, negedge HRESET)
  begin
    if (!HRESET)
    begin
      state <= EngIdle;
      roundCnt <= '0;
    end
    else
    begin
      case (state)
        EngIdle:
          if (pass.valid)
          begin
            state <= EngRound;
            roundCnt <= '0;
          end
        EngRound:
        begin
          roundCnt <= roundCnt + 4'd1;
          if (roundCnt == 4'(`DES_ROUNDS - 1))
            state <= EngFinal;
        end
        EngFinal: state <= EngDone;
        default:
          if (pass.resultReady)
            state <= EngIdle;
      endcase
    end
  end

  always_ff @(posedge HCLK)
  begin
    case (state)
      EngIdle:
        if (pass.valid)
        begin
          data.word <= initialPerm(pass.block.word);
          cd <= pc1(pass.key);
          dir <= pass.dir;
        end
      EngRound:
      begin
        data <= nextData;
        cd <= nextCd;
      end
      // Undo the last half swap before the final permutation
      EngFinal: data.word <= finalPerm({data.halves.right, data.halves.left});
      default: ;
    endcase
  end

  assign pass.ready = (state == EngIdle);
  assign pass.resultValid = (state == EngDone);
  assign pass.result = data;

endmodule

// File: hdl/TripleDesSequencer.sv
`timescale 1ns/1ps

module TripleDesSequencer
(
  input logic HCLK,
  input logic HRESET,
  TdesReqIf.sequencer req,
  DesPassIf.requester pass
);

  typedef enum logic [1:0] {SeqIdle, SeqIssue, SeqWait, SeqDone} SeqState;

  SeqState state;
  logic [1:0] passCnt;
  DesPkg::CipherDir dir;
  DesPkg::DesKey key1;
  DesPkg::DesKey key2;
  DesPkg::DesKey key3;
  DesPkg::DesBlock block;

  always_ff @(posedge HCLK, negedge HRESET)
  begin
    if (!HRESET)
    begin
      state <= SeqIdle;
      passCnt <= '0;
    end
    else
    begin
      case (state)
        SeqIdle:
          if (req.valid)
          begin
            state <= SeqIssue;
            passCnt <= '0;
          end
        SeqIssue:
          if (pass.ready)
            state <= SeqWait;
        SeqWait:
          if (pass.resultValid)
          begin
            if (passCnt == 2'd2)
              state <= SeqDone;
            else
            begin
              state <= SeqIssue;
              passCnt <= passCnt + 2'd1;
            end
          end
        default:
          if (req.resultReady)
            state <= SeqIdle;
      endcase
    end
  end

  // Keys are captured so bus writes cannot disturb a block in flight
  always_ff @(posedge HCLK)
  begin
    if (state == SeqIdle && req.valid)
    begin
      block <= req.block;
      dir <= req.dir;
      key1 <= req.key1;
      key2 <= req.key2;
      key3 <= req.key3;
    end
    else if (state == SeqWait && pass.resultValid)
      block <= pass.result;
  end

  // EDE order, mirrored for decryption
  always_comb
  begin
    if (passCnt == 2'd1)
      pass.dir = (dir == DesPkg::Encrypt) ? DesPkg::Decrypt : DesPkg::Encrypt;
    else
      pass.dir = dir;
    case (passCnt)
      2'd0: pass.key = (dir == DesPkg::Encrypt) ? key1 : key3;
      2'd1: pass.key = key2;
      default: pass.key = (dir == DesPkg::Encrypt) ? key3 : key1;
    endcase
  end

  assign pass.valid = (state == SeqIssue);
  assign pass.block = block;
  assign pass.resultReady = (state == SeqWait);
  assign req.ready = (state == SeqIdle);
  assign req.resultValid = (state == SeqDone);
  assign req.result = block;

endmodule

// File: hdl/AhbSlaveController.sv
`timescale 1ns/1ps
`include "TripleDes_defs.svh"

module AhbSlaveController
(
  input logic HCLK,
  input logic HRESET,
  input logic HSEL,
  input logic [31:0] HADDR,
  input AhbPkg::HtransType HTRANS,
  input logic HWRITE,
  input logic [2:0] HSIZE,
  input logic [2:0] HBURST,
  input logic HMASTLOCK,
  input logic HREADY,
  input logic [63:0] HWDATA,
  output logic [63:0] HRDATA,
  output logic HREADYOUT,
  output logic HRESP,
  TdesReqIf.controller req
);

  AhbPkg::RegIndex addrReg;
  AhbPkg::RegIndex phaseReg;
  logic transfer;
  logic illegal;
  logic phaseActive;
  logic phaseWrite;
  logic phaseError;
  logic errLate;
  logic writeNow;
  logic resultRead;
  logic resultDone;
  logic resultFull;
  logic [63:0] modeReg;
  DesPkg::DesKey key1Reg;
  DesPkg::DesKey key2Reg;
  DesPkg::DesKey key3Reg;
  DesPkg::DesBlock dataReg;
  DesPkg::DesBlock resultReg;

  always_comb
  begin
    case (HADDR)
      (`TDES_BASE + `TDES_MODE_OFS): addrReg = AhbPkg::RegMode;
      (`TDES_BASE + `TDES_KEY1_OFS): addrReg = AhbPkg::RegKey1;
      (`TDES_BASE + `TDES_KEY2_OFS): addrReg = AhbPkg::RegKey2;
      (`TDES_BASE + `TDES_KEY3_OFS): addrReg = AhbPkg::RegKey3;
      (`TDES_BASE + `TDES_DATA_OFS): addrReg = AhbPkg::RegDataIn;
      (`TDES_BASE + `TDES_RESULT_OFS): addrReg = AhbPkg::RegResult;
      default: addrReg = AhbPkg::RegNone;
    endcase
  end

  assign transfer = HSEL && HREADY &&
                    (HTRANS == AhbPkg::TransNonSeq || HTRANS == AhbPkg::TransSeq);

  // Only single 64-bit unlocked accesses to mapped registers
  assign illegal = (HSIZE != 3'b011) || (HBURST != 3'b000) || HMASTLOCK ||
                   (addrReg == AhbPkg::RegNone) ||
                   (HWRITE && addrReg == AhbPkg::RegResult);

  assign writeNow = phaseActive && !phaseError && phaseWrite && HREADYOUT;
  assign resultRead = phaseActive && !phaseError && !phaseWrite &&
                      (phaseReg == AhbPkg::RegResult);
  assign resultDone = resultRead && HREADYOUT;

  always_ff @(posedge HCLK, negedge HRESET)
  begin
    if (!HRESET)
    begin
      phaseActive <= 1'b0;
      phaseWrite <= 1'b0;
      phaseError <= 1'b0;
      phaseReg <= AhbPkg::RegNone;
      errLate <= 1'b0;
      resultFull <= 1'b0;
      modeReg <= '0;
    end
    else
    begin
      errLate <= phaseActive && phaseError && !errLate;
      if (HREADY)
      begin
        phaseActive <= transfer;
        phaseWrite <= HWRITE;
        phaseError <= transfer && illegal;
        phaseReg <= addrReg;
      end
      if (writeNow && phaseReg == AhbPkg::RegMode)
        modeReg <= HWDATA;
      // Park a finished result until the master reads it
      if (resultDone)
        resultFull <= 1'b0;
      else if (req.resultValid && req.resultReady)
        resultFull <= 1'b1;
    end
  end

  always_ff @(posedge HCLK)
  begin
    if (writeNow)
    begin
      case (phaseReg)
        AhbPkg::RegKey1: key1Reg <= HWDATA;
        AhbPkg::RegKey2: key2Reg <= HWDATA;
        AhbPkg::RegKey3: key3Reg <= HWDATA;
        AhbPkg::RegDataIn: dataReg.word <= HWDATA;
        default: ;
      endcase
    end
    if (req.resultValid && req.resultReady && !resultDone)
      resultReg <= req.result;
  end

  always_comb
  begin
    HRESP = 1'b0;
    HREADYOUT = 1'b1;
    HRDATA = '0;
    if (phaseActive && phaseError)
    begin
      HRESP = 1'b1;
      HREADYOUT = errLate;
    end
    else if (phaseActive && phaseWrite)
    begin
      // Data write stalls while the previous block is busy
      if (phaseReg == AhbPkg::RegDataIn)
        HREADYOUT = req.ready;
    end
    else if (phaseActive)
    begin
      case (phaseReg)
        AhbPkg::RegMode: HRDATA = modeReg;
        AhbPkg::RegKey1: HRDATA = key1Reg;
        AhbPkg::RegKey2: HRDATA = key2Reg;
        AhbPkg::RegKey3: HRDATA = key3Reg;
        AhbPkg::RegDataIn: HRDATA = dataReg.word;
        AhbPkg::RegResult:
        begin
          HREADYOUT = resultFull || req.resultValid;
          HRDATA = resultFull ? resultReg.word : req.result.word;
        end
        default: HRDATA = '0;
      endcase
    end
  end

  assign req.valid = phaseActive && !phaseError && phaseWrite &&
                     (phaseReg == AhbPkg::RegDataIn);
  assign req.block = DesPkg::DesBlock'(HWDATA);
  assign req.dir = DesPkg::CipherDir'(modeReg[0]);
  assign req.key1 = key1Reg;
  assign req.key2 = key2Reg;
  assign req.key3 = key3Reg;
  assign req.resultReady = !resultFull;

endmodule

// File: hdl/DesInterfaces.sv
`timescale 1ns/1ps

// Block request from the bus controller to the EDE sequencer
interface TdesReqIf;
  logic valid;
  logic ready;
  DesPkg::DesBlock block;
  DesPkg::CipherDir dir;
  DesPkg::DesKey key1;
  DesPkg::DesKey key2;
  DesPkg::DesKey key3;
  logic resultValid;
  logic resultReady;
  DesPkg::DesBlock result;

  modport controller (output valid, block, dir, key1, key2, key3, resultReady,
                      input ready, resultValid, result);
  modport sequencer (input valid, block, dir, key1, key2, key3, resultReady,
                     output ready, resultValid, result);
endinterface

// Single DES pass from the sequencer to the engine
interface DesPassIf;
  logic valid;
  logic ready;
  DesPkg::DesBlock block;
  DesPkg::DesKey key;
  DesPkg::CipherDir dir;
  logic resultValid;
  logic resultReady;
  DesPkg::DesBlock result;

  modport requester (output valid, block, key, dir, resultReady,
                     input ready, resultValid, result);
  modport engine (input valid, block, key, dir, resultReady,
                  output ready, resultValid, result);
endinterface

// File: hdl/DesPkg.sv
package DesPkg;

  // DES bit 1 is the MSB, so the left half sits in the upper word
  typedef struct packed
  {
    logic [31:0] left;
    logic [31:0] right;
  } DesHalves;

  // One cipher block, as a bus word or as Feistel halves
  typedef union packed
  {
    logic [63:0] word;
    DesHalves halves;
  } DesBlock;

  // Key with parity bits still in place
  typedef logic [63:0] DesKey;

  typedef enum logic
  {
    Encrypt = 1'b0,
    Decrypt = 1'b1
  } CipherDir;

endpackage

// File: hdl/AhbPkg.sv
package AhbPkg;

  // AHB HTRANS encodings
  typedef enum logic [1:0]
  {
    TransIdle = 2'b00,
    TransBusy = 2'b01,
    TransNonSeq = 2'b10,
    TransSeq = 2'b11
  } HtransType;

  // Decoded register of an address phase
  typedef enum logic [2:0]
  {
    RegMode = 3'd0,
    RegKey1 = 3'd1,
    RegKey2 = 3'd2,
    RegKey3 = 3'd3,
    RegDataIn = 3'd4,
    RegResult = 3'd5,
    RegNone = 3'd7
  } RegIndex;

endpackage

// File: hdl/TripleDes_defs.svh
`ifndef TRIPLEDES_DEFS_SVH
`define TRIPLEDES_DEFS_SVH

// Register block base
`define TDES_BASE 32'hAAAAAAA0

// Register offsets, one 64-bit word each
`define TDES_MODE_OFS 32'h00
`define TDES_KEY1_OFS 32'h08
`define TDES_KEY2_OFS 32'h10
`define TDES_KEY3_OFS 32'h18
`define TDES_DATA_OFS 32'h20
`define TDES_RESULT_OFS 32'h28

// Feistel rounds per DES pass
`define DES_ROUNDS 16

`endif
